// ==== include/oflow_mem_cfg.svh ====
// object-flow memory configuration
`ifndef OFLOW_MEM_CFG_SVH
`define OFLOW_MEM_CFG_SVH

// record and address widths
`define OFLOW_DATA_WIDTH 32 // one bounding-box record
`define OFLOW_ADDR_WIDTH 8 // address into the dual-port memory

// memory sizing
`define OFLOW_MEM_DEPTH 256 // physical words
`define OFLOW_USED_WORDS 250 // words split among the history regions

// record index inside one region
`define OFLOW_OFFSET_WIDTH 6

// frame bookkeeping
`define OFLOW_FRAME_WIDTH 8 // serial frame counter, wraps at 256
`define OFLOW_MAX_HISTORY 5 // largest number of kept frames
`define OFLOW_HIST_WIDTH 3 // enough bits for 1 to 5

`endif

// ==== verilog/oflow_mem_pkg.sv ====
// memory word and address types
`include "oflow_mem_cfg.svh"

package oflow_mem_pkg;

	// one bounding-box record as stored in memory
	typedef logic [`OFLOW_DATA_WIDTH-1:0] data_t;

	// word address into the 256-word memory
	typedef logic [`OFLOW_ADDR_WIDTH-1:0] addr_t;

	// record index relative to the region base
	typedef logic [`OFLOW_OFFSET_WIDTH-1:0] offset_t;

endpackage

// ==== verilog/oflow_frame_pkg.sv ====
// frame bookkeeping types
`include "oflow_mem_cfg.svh"

package oflow_frame_pkg;

	// serial number of the current frame, 0 to 255
	typedef logic [`OFLOW_FRAME_WIDTH-1:0] frame_num_t;

	// number of history frames kept, 1 to 5
	typedef logic [`OFLOW_HIST_WIDTH-1:0] hist_t;

	// region index of the current frame, 0 to history-1
	typedef logic [`OFLOW_HIST_WIDTH-1:0] slot_t;

endpackage

// ==== verilog/oflow_dp_mem.sv ====
// dual-port record memory
`timescale 1ns/1ps
`include "oflow_mem_cfg.svh"

module oflow_dp_mem (
	input logic clk,
	input logic reset_N,
	input oflow_mem_pkg::addr_t address_0, // port 0 word address
	input oflow_mem_pkg::addr_t address_1, // port 1 word address
	input oflow_mem_pkg::data_t data_in_0,
	input oflow_mem_pkg::data_t data_in_1,
	input logic cs_0, // port 0 select
	input logic cs_1, // port 1 select
	input logic we_0, // port 0 write
	input logic we_1, // port 1 write
	input logic oe_0, // port 0 read
	input logic oe_1, // port 1 read
	output oflow_mem_pkg::data_t data_out_0,
	output oflow_mem_pkg::data_t data_out_1
);

	oflow_mem_pkg::data_t mem_array [`OFLOW_MEM_DEPTH]; // record storage, no reset

	logic wr_0; // qualified write strobes
	logic wr_1;
	logic rd_0; // qualified read strobes
	logic rd_1;

	assign wr_0 = cs_0 & we_0;
	assign wr_1 = cs_1 & we_1;
	assign rd_0 = cs_0 & oe_0;
	assign rd_1 = cs_1 & oe_1;

	// write side
	// port 1 is written last so it wins a same-address collision
	always_ff @(posedge clk) begin
		if (wr_0) begin
			mem_array[address_0] <= data_in_0;
		end
		if (wr_1) begin
			mem_array[address_1] <= data_in_1; // overrides port 0 on equal address
		end
	end

	// read side, one cycle latency
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			data_out_0 <= '0; // outputs start clean
		end else if (rd_0) begin
			data_out_0 <= mem_array[address_0]; // old word on read-during-write
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_N) begin
			data_out_1 <= '0;
		end else if (rd_1) begin
			data_out_1 <= mem_array[address_1]; // holds when not reading
		end
	end

	// a port is either writing or reading, never both
	a_port0_we_oe: assert property (
		@(posedge clk) disable iff (!reset_N)
		!(we_0 && oe_0)
	) else $error("port 0 has we and oe high together");

	a_port1_we_oe: assert property (
		@(posedge clk) disable iff (!reset_N)
		!(we_1 && oe_1)
	) else $error("port 1 has we and oe high together");

endmodule

// ==== verilog/oflow_frame_ctrl.sv ====
// frame and slot counter
`timescale 1ns/1ps
`include "oflow_mem_cfg.svh"

module oflow_frame_ctrl (
	input logic clk,
	input logic reset_N,
	input logic frame_start, // one-cycle pulse per new frame
	input oflow_frame_pkg::hist_t history_cfg, // requested history count
	output oflow_frame_pkg::frame_num_t frame_num, // serial frame number
	output oflow_frame_pkg::slot_t slot, // region of the current frame
	output oflow_frame_pkg::hist_t history // active history count
);

	oflow_frame_pkg::hist_t hist_sane; // history_cfg clamped to a legal value
	oflow_frame_pkg::slot_t slot_last; // last slot before wrapping
	logic frame_last; // frame_num sits at 255
	logic frame_wrap; // this frame_start rolls frame_num to 0

	// 0 and anything above the maximum fall back to a single region
	always_comb begin
		if (history_cfg == '0 || history_cfg > `OFLOW_MAX_HISTORY) begin
			hist_sane = oflow_frame_pkg::hist_t'(1);
		end else begin
			hist_sane = history_cfg;
		end
	end

	assign slot_last = oflow_frame_pkg::slot_t'(history - 1'b1);
	assign frame_last = (frame_num == {`OFLOW_FRAME_WIDTH{1'b1}});
	assign frame_wrap = frame_start & frame_last;

	// serial frame counter, natural wrap at 256
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			frame_num <= '0;
		end else if (frame_start) begin
			frame_num <= frame_num + 1'b1;
		end
	end

	// slot runs alongside frame_num so no modulo is needed
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			slot <= '0;
		end else if (frame_start) begin
			if (frame_last || slot == slot_last) begin
				slot <= '0; // restart on frame wrap or region wrap
			end else begin
				slot <= slot + 1'b1;
			end
		end
	end

	// history only changes at reset and at the frame wrap
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			history <= hist_sane; // sampled straight out of reset
		end else if (frame_wrap) begin
			history <= hist_sane; // new layout starts with frame 0
		end
	end

	// slot must always address a live region
	a_slot_in_range: assert property (
		@(posedge clk) disable iff (!reset_N)
		slot < history
	) else $error("slot %0d not below history %0d", slot, history);

	// history must stay a legal count
	a_history_legal: assert property (
		@(posedge clk) disable iff (!reset_N)
		(history >= 1) && (history <= `OFLOW_MAX_HISTORY)
	) else $error("history %0d out of range", history);

endmodule

// ==== verilog/oflow_mem_buffer.sv ====
// history region buffer
`timescale 1ns/1ps
`include "oflow_mem_cfg.svh"

module oflow_mem_buffer (
	input logic clk,
	input logic reset_N,
	input oflow_frame_pkg::slot_t slot, // region of the current frame
	input oflow_frame_pkg::hist_t history, // number of regions
	input oflow_mem_pkg::offset_t offset_0, // record index, port 0
	input oflow_mem_pkg::offset_t offset_1, // record index, port 1
	input logic we, // high writes, low reads
	input oflow_mem_pkg::data_t data_in_0,
	input oflow_mem_pkg::data_t data_in_1,
	output oflow_mem_pkg::data_t data_out_0,
	output oflow_mem_pkg::data_t data_out_1
);

	oflow_mem_pkg::addr_t region_base [`OFLOW_MAX_HISTORY]; // start word per region
	oflow_mem_pkg::addr_t slot_base; // base of the active region
	oflow_mem_pkg::addr_t address_0; // final word addresses
	oflow_mem_pkg::addr_t address_1;
	logic oe; // read enable for both ports

	// region k starts at k * ceil(250 / history)
	always_comb begin
		for (int k = 0; k < `OFLOW_MAX_HISTORY; k++) begin
			region_base[k] = '0; // unused entries stay zero
		end
		case (history)
			3'd2: begin
				region_base[1] = 8'd125;
			end
			3'd3: begin
				region_base[1] = 8'd84;
				region_base[2] = 8'd168;
			end
			3'd4: begin
				region_base[1] = 8'd63;
				region_base[2] = 8'd126;
				region_base[3] = 8'd189;
			end
			3'd5: begin
				region_base[1] = 8'd50;
				region_base[2] = 8'd100;
				region_base[3] = 8'd150;
				region_base[4] = 8'd200;
			end
			default: begin
				region_base[0] = '0; // single region covers the used words
			end
		endcase
	end

	// guard the index, slot is 3 bits but only 5 entries exist
	assign slot_base = (slot < `OFLOW_MAX_HISTORY) ? region_base[slot] : '0;

	// both addresses share the base, wrap mod 256
	assign address_0 = slot_base + oflow_mem_pkg::addr_t'(offset_0);
	assign address_1 = slot_base + oflow_mem_pkg::addr_t'(offset_1);

	assign oe = ~we; // read whenever not writing

	oflow_dp_mem u_dp_mem (
		.clk        (clk),
		.reset_N    (reset_N),
		.address_0  (address_0),
		.address_1  (address_1),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.cs_0       (1'b1),
		.cs_1       (1'b1),
		.we_0       (we),
		.we_1       (we),
		.oe_0       (oe),
		.oe_1       (oe),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	// slot and history come from the frame controller
	// together they must pick a base inside the shared words
	a_base_in_used: assert property (
		@(posedge clk) disable iff (!reset_N)
		(slot < history) |-> (slot_base < `OFLOW_USED_WORDS)
	) else $error("region base %0d outside used words", slot_base);

endmodule

// ==== verilog/oflow_mem_top.sv ====
// object-flow frame history top
`timescale 1ns/1ps
`include "oflow_mem_cfg.svh"

module oflow_mem_top (
	input logic clk,
	input logic reset_N,
	input logic frame_start, // advance to the next frame
	input oflow_frame_pkg::hist_t history_cfg, // requested history count
	input logic we, // high writes, low reads
	input oflow_mem_pkg::offset_t offset_0,
	input oflow_mem_pkg::offset_t offset_1,
	input oflow_mem_pkg::data_t data_in_0,
	input oflow_mem_pkg::data_t data_in_1,
	output oflow_mem_pkg::data_t data_out_0,
	output oflow_mem_pkg::data_t data_out_1,
	output oflow_frame_pkg::frame_num_t frame_num // current frame serial
);

	oflow_frame_pkg::slot_t slot; // active region index
	oflow_frame_pkg::hist_t history; // latched region count

	// frame counting and region selection
	oflow_frame_ctrl u_frame_ctrl (
		.clk         (clk),
		.reset_N     (reset_N),
		.frame_start (frame_start),
		.history_cfg (history_cfg),
		.frame_num   (frame_num),
		.slot        (slot),
		.history     (history)
	);

	// region table, address forming and storage
	oflow_mem_buffer u_mem_buffer (
		.clk        (clk),
		.reset_N    (reset_N),
		.slot       (slot),
		.history    (history),
		.offset_0   (offset_0),
		.offset_1   (offset_1),
		.we         (we),
		.data_in_0  (data_in_0),
		.data_in_1  (data_in_1),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

endmodule

// ==== tests/tb_oflow_mem_top.sv ====
// object-flow buffer testbench
`timescale 1ns/1ps
`include "oflow_mem_cfg.svh"

module tb_oflow_mem_top;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 16;
	localparam int WRAP_CYCLES = 257; // worst case pulses until frame_num rolls to 0
	localparam int FILL_CYCLES = 48; // mixed traffic inside the first frame
	localparam int RANDOM_CYCLES = 800; // random pulses, traffic and history_cfg
	localparam int PLANNED_CYCLES = RESET_CYCLES + FILL_CYCLES
		+ 5 * (WRAP_CYCLES + 4 * `OFLOW_MAX_HISTORY)
		+ RANDOM_CYCLES + 16 + 3 * (WRAP_CYCLES + 8);

	logic clk;
	logic reset_N;
	logic frame_start;
	oflow_frame_pkg::hist_t history_cfg;
	logic we;
	oflow_mem_pkg::offset_t offset_0;
	oflow_mem_pkg::offset_t offset_1;
	oflow_mem_pkg::data_t data_in_0;
	oflow_mem_pkg::data_t data_in_1;
	oflow_mem_pkg::data_t data_out_0;
	oflow_mem_pkg::data_t data_out_1;
	oflow_frame_pkg::frame_num_t frame_num;

	// reference model state
	oflow_mem_pkg::data_t model_mem [`OFLOW_MEM_DEPTH]; // words as the rules say they hold
	bit model_valid [`OFLOW_MEM_DEPTH]; // word written at least once
	oflow_frame_pkg::frame_num_t model_frame;
	oflow_frame_pkg::slot_t model_slot;
	oflow_frame_pkg::hist_t model_hist;
	oflow_mem_pkg::data_t exp_out_0; // expected registered outputs
	oflow_mem_pkg::data_t exp_out_1;
	bit exp_valid_0; // compare only known words
	bit exp_valid_1;
	logic [31:0] rng_state;

	oflow_mem_top UUT (
		.clk         (clk),
		.reset_N     (reset_N),
		.frame_start (frame_start),
		.history_cfg (history_cfg),
		.we          (we),
		.offset_0    (offset_0),
		.offset_1    (offset_1),
		.data_in_0   (data_in_0),
		.data_in_1   (data_in_1),
		.data_out_0  (data_out_0),
		.data_out_1  (data_out_1),
		.frame_num   (frame_num)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// hard stop if the sequence never reaches its end
	initial begin
		#(PLANNED_CYCLES * CLK_PERIOD * 2);
		$display("timeout: the test sequence did not finish in the planned time");
		$display("Result: FAILED");
		$fatal(1, "simulation timed out");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// 0 and values above five fall back to one region
	function automatic oflow_frame_pkg::hist_t legal_history(input oflow_frame_pkg::hist_t cfg);
		oflow_frame_pkg::hist_t h;
		if (cfg == 3'd0 || cfg > 3'd5) begin
			h = 3'd1;
		end else begin
			h = cfg;
		end
		return h;
	endfunction

	// ceil(used words / history)
	function automatic int region_words(input oflow_frame_pkg::hist_t h);
		int n;
		n = int'(h);
		return (`OFLOW_USED_WORDS + n - 1) / n;
	endfunction

	function automatic oflow_mem_pkg::addr_t record_addr(input oflow_frame_pkg::slot_t s,
			input oflow_frame_pkg::hist_t h, input oflow_mem_pkg::offset_t off);
		int a;
		a = int'(s) * region_words(h) + int'(off); // base of region plus offset
		return oflow_mem_pkg::addr_t'(a % `OFLOW_MEM_DEPTH); // wraps mod 256
	endfunction

	task automatic next_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// offset kept below the region size of the active history
	task automatic random_offset(input int cap, output oflow_mem_pkg::offset_t o);
		logic [31:0] r;
		int limit;
		limit = region_words(model_hist);
		if (limit > cap) begin
			limit = cap;
		end
		next_random(r);
		o = oflow_mem_pkg::offset_t'(r % 32'(limit));
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		assert (got === exp) else begin
			$display("FAILED at %0d ns: %s is %h, expected %h", $time, what, got, exp);
			$display("Result: FAILED");
			$fatal(1, "output mismatch");
		end
	endtask

	// what the DUT does at one rising edge
	task automatic model_edge(input logic fs, input logic w,
			input oflow_mem_pkg::offset_t o0, input oflow_mem_pkg::offset_t o1,
			input oflow_mem_pkg::data_t d0, input oflow_mem_pkg::data_t d1);
		oflow_mem_pkg::addr_t a0;
		oflow_mem_pkg::addr_t a1;
		a0 = record_addr(model_slot, model_hist, o0); // slot before this edge
		a1 = record_addr(model_slot, model_hist, o1);
		if (w) begin
			model_mem[a0] = d0;
			model_valid[a0] = 1'b1;
			model_mem[a1] = d1; // port 1 last, wins on equal address
			model_valid[a1] = 1'b1;
		end else begin
			exp_out_0 = model_mem[a0];
			exp_valid_0 = model_valid[a0];
			exp_out_1 = model_mem[a1];
			exp_valid_1 = model_valid[a1];
		end
		if (fs) begin
			if (model_frame == 8'd255) begin
				model_slot = 3'd0; // frame wrap restarts the regions
				model_hist = legal_history(history_cfg); // only moment cfg is taken
			end else if (model_slot == model_hist - 3'd1) begin
				model_slot = 3'd0;
			end else begin
				model_slot = model_slot + 3'd1;
			end
			model_frame = model_frame + 8'd1;
		end
	endtask

	task automatic check_outputs();
		check_word(32'(frame_num), 32'(model_frame), "frame_num");
		if (exp_valid_0) begin
			check_word(data_out_0, exp_out_0, "data_out_0");
		end
		if (exp_valid_1) begin
			check_word(data_out_1, exp_out_1, "data_out_1");
		end
	endtask

	// drive at edge plus 1 ns, model the edge, check after it
	task automatic run_cycle(input logic fs, input logic w,
			input oflow_mem_pkg::offset_t o0, input oflow_mem_pkg::offset_t o1,
			input oflow_mem_pkg::data_t d0, input oflow_mem_pkg::data_t d1);
		frame_start = fs;
		we = w;
		offset_0 = o0;
		offset_1 = o1;
		data_in_0 = d0;
		data_in_1 = d1;
		@(posedge clk);
		model_edge(fs, w, o0, o1, d0, d1);
		#1;
		check_outputs();
	endtask

	task automatic random_cycle(input logic fs, input int cap);
		logic [31:0] r;
		logic [31:0] d0;
		logic [31:0] d1;
		oflow_mem_pkg::offset_t o0;
		oflow_mem_pkg::offset_t o1;
		next_random(r);
		next_random(d0);
		next_random(d1);
		random_offset(cap, o0);
		random_offset(cap, o1);
		run_cycle(fs, r[7], o0, o1, d0, d1);
	endtask

	// pulse frame_start with random traffic until frame_num has rolled over to 0
	task automatic goto_wrap(input oflow_frame_pkg::hist_t cfg);
		history_cfg = cfg;
		do begin
			random_cycle(1'b1, 64);
		end while (model_frame != 8'd0);
	endtask

	initial begin
		logic [31:0] r;
		logic [31:0] d0;
		logic [31:0] d1;
		oflow_mem_pkg::offset_t o0;
		oflow_mem_pkg::offset_t o1;
		oflow_frame_pkg::hist_t bad_cfg [3];

		reset_N = 1'b0;
		frame_start = 1'b0;
		history_cfg = 3'd4; // four regions out of reset
		we = 1'b0;
		offset_0 = '0;
		offset_1 = '0;
		data_in_0 = '0;
		data_in_1 = '0;
		rng_state = 32'hbdac_bc66;
		for (int i = 0; i < `OFLOW_MEM_DEPTH; i++) begin
			model_valid[i] = 1'b0; // memory is not reset
			model_mem[i] = '0;
		end
		model_frame = '0;
		model_slot = '0;
		exp_out_0 = '0; // outputs clear on reset
		exp_out_1 = '0;
		exp_valid_0 = 1'b1;
		exp_valid_1 = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		model_hist = legal_history(history_cfg);
		#1;
		reset_N = 1'b1;

		// state right after reset
		check_word(data_out_0, 32'd0, "data_out_0 after reset");
		check_word(data_out_1, 32'd0, "data_out_1 after reset");
		check_word(32'(frame_num), 32'd0, "frame_num after reset");

		// dense writes and reads inside one frame
		for (int i = 0; i < FILL_CYCLES; i++) begin
			random_cycle(1'b0, 32);
		end

		// each history count, one record pair per region, then read all back
		for (int h = 1; h <= `OFLOW_MAX_HISTORY; h++) begin
			goto_wrap(oflow_frame_pkg::hist_t'(h));
			random_offset(64, o0);
			random_offset(64, o1);
			for (int s = 0; s < h; s++) begin
				next_random(d0);
				next_random(d1);
				run_cycle(1'b0, 1'b1, o0, o1, d0, d1); // write into slot s
				run_cycle(1'b1, 1'b0, o0, o1, '0, '0); // step to the next slot
			end
			for (int s = 0; s < h; s++) begin
				run_cycle(1'b0, 1'b0, o0, o1, '0, '0); // read slot s
				run_cycle(1'b1, 1'b0, o0, o1, '0, '0);
			end
		end

		// random pulses with history_cfg churning, only a wrap picks it up
		for (int i = 0; i < RANDOM_CYCLES; i++) begin
			next_random(r);
			history_cfg = r[4:2];
			random_cycle(r[0] | r[1], 64);
		end

		// same address on both ports, port 1 stores
		random_offset(64, o0);
		next_random(d0);
		next_random(d1);
		run_cycle(1'b0, 1'b1, o0, o0, d0, d1);
		run_cycle(1'b0, 1'b0, o0, o0, '0, '0);
		check_word(data_out_0, d1, "port 0 read after collision");
		check_word(data_out_1, d1, "port 1 read after collision");
		for (int i = 0; i < 4; i++) begin
			next_random(r);
			run_cycle(1'b0, 1'b1, o0 ^ 6'd1, o0 ^ 6'd2, r, ~r); // held write
			check_word(data_out_0, d1, "data_out_0 while we held");
			check_word(data_out_1, d1, "data_out_1 while we held");
		end
		run_cycle(1'b0, 1'b0, o0, o0, '0, '0); // collision word survives the writes
		check_word(data_out_0, d1, "port 0 read after held writes");

		// illegal history counts act as a single region at base 0
		bad_cfg[0] = 3'd0;
		bad_cfg[1] = 3'd6;
		bad_cfg[2] = 3'd7;
		for (int k = 0; k < 3; k++) begin
			goto_wrap(bad_cfg[k]);
			random_offset(64, o0);
			o1 = o0 ^ 6'd1; // keep ports apart
			next_random(d0);
			next_random(d1);
			run_cycle(1'b0, 1'b1, o0, o1, d0, d1); // frame 0
			run_cycle(1'b1, 1'b0, o0, o1, '0, '0);
			run_cycle(1'b0, 1'b0, o0, o1, '0, '0); // frame 1 sees the same words
			check_word(data_out_0, d0, "port 0 with illegal history");
			check_word(data_out_1, d1, "port 1 with illegal history");
			run_cycle(1'b1, 1'b0, o0, o1, '0, '0);
			run_cycle(1'b0, 1'b0, o0, o1, '0, '0); // frame 2 as well
			check_word(data_out_0, d0, "port 0 two frames on");
		end

		frame_start = 1'b0;
		we = 1'b0;
		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== oflow_mem_top.f ====
+incdir+include
verilog/oflow_mem_pkg.sv
verilog/oflow_frame_pkg.sv
verilog/oflow_dp_mem.sv
verilog/oflow_frame_ctrl.sv
verilog/oflow_mem_buffer.sv
verilog/oflow_mem_top.sv
tests/tb_oflow_mem_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the object-flow buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"
rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module tb_oflow_mem_top \
	-f oflow_mem_top.f \
	-o tb_oflow_mem_top \
	&& ./obj_dir/tb_oflow_mem_top 2>&1 | tee "$LOG" \
	|| echo "build or simulation exited with an error"

touch "$LOG"

grep -q "^Result: PASSED$" "$LOG" \
	&& echo "simulation passed" \
	&& exit 0 \
	|| { echo "simulation failed, see $LOG"; exit 1; }
